// File: source/mem_macros.svh
/* Memory unit widths and sizes */

`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// Address split
`define VADDR_WIDTH 16
`define PADDR_WIDTH 12
`define PAGE_OFFSET_WIDTH 8
`define VTAG_WIDTH 8
`define PTAG_WIDTH 4

// Data path
`define DATA_WIDTH 32

// Storage
`define DTLB_ENTRIES 4
`define DMEM_WORDS 1024

`endif

// File: source/mmu_pkg.sv
/* Memory command and response types */

`include "mem_macros.svh"

package mmu_pkg;

  typedef enum logic [2:0] {
    e_lw,
    e_lbu,
    e_sw,
    e_sb,
    e_itlb_fill
  } mem_op_e;

  typedef struct packed {
    mem_op_e                 op;
    logic [`VADDR_WIDTH-1:0] vaddr;
    logic [`DATA_WIDTH-1:0]  data;
  } mmu_cmd_s;

  // Decoded operation carried to the result stage
  typedef struct packed {
    logic       is_load;
    logic       is_store;
    logic       is_byte;
    logic       is_fill;
    logic [1:0] byte_off;
  } op_dec_s;

  typedef struct packed {
    logic [`DATA_WIDTH-1:0] data;
    logic                   miss_v;
    logic                   exc_v;
  } mem_resp_s;

endpackage

// File: source/vm_pkg.sv
/* Page table and TLB types */

`include "mem_macros.svh"

package vm_pkg;

  // PTE bit positions
  localparam int unsigned pte_v_bit   = 0;
  localparam int unsigned pte_r_bit   = 1;
  localparam int unsigned pte_w_bit   = 2;
  localparam int unsigned pte_ppn_lsb = 4;

  typedef struct packed {
    logic [`DATA_WIDTH-9:0] rsvd_hi;
    logic [`PTAG_WIDTH-1:0] ppn;
    logic                   rsvd;
    logic                   w;
    logic                   r;
    logic                   v;
  } pte_s;

  typedef struct packed {
    logic [`PTAG_WIDTH-1:0] ptag;
    logic                   r;
    logic                   w;
  } tlb_entry_s;

endpackage

// File: source/tlb_fill_if.sv
/* TLB fill path */

`timescale 1ns/1ps
`include "mem_macros.svh"

interface tlb_fill_if;
  import vm_pkg::*;

  logic                   w_v;
  logic [`VTAG_WIDTH-1:0] vtag;
  tlb_entry_s             entry;
  // Set when the walk was for the instruction side
  logic                   itlb_not_dtlb;

  modport walker (
    output w_v, vtag, entry, itlb_not_dtlb
  );

  modport tlb (
    input w_v, vtag, entry, itlb_not_dtlb
  );

endinterface

// File: source/mmu_cmd_decode.sv
/* Command decode and translation */

`timescale 1ns/1ps
`include "mem_macros.svh"

module mmu_cmd_decode (
  input  logic                       clk_i
  , input  logic                     reset_i
  , input  logic                     cmd_v_i
  , input  mmu_pkg::mmu_cmd_s        cmd_i
  , input  logic                     busy_i
  , input  logic                     translation_en_i
  , input  logic                     lookup_hit_i
  , input  vm_pkg::tlb_entry_s       lookup_entry_i
  , output logic [`VTAG_WIDTH-1:0]   lookup_vtag_o
  , output logic                     dmem_v_o
  , output logic                     dmem_we_o
  , output logic [`PADDR_WIDTH-3:0]  dmem_addr_o
  , output logic [`DATA_WIDTH-1:0]   dmem_wdata_o
  , output logic [`DATA_WIDTH/8-1:0] dmem_mask_o
  , output logic                     walk_v_o
  , output logic [`VTAG_WIDTH-1:0]   walk_vtag_o
  , output logic                     walk_is_store_o
  , output logic                     walk_is_fill_o
  , output logic                     stage_v_o
  , output mmu_pkg::op_dec_s         stage_dec_o
  , output logic                     stage_miss_o
  , output logic                     stage_exc_o
);
  import mmu_pkg::*;

  op_dec_s                 dec, dec_q;
  logic                    accept, miss, exc;
  logic                    stage_v_q, miss_q, exc_q;
  logic [`PADDR_WIDTH-1:0] paddr;
  logic [`VTAG_WIDTH-1:0]  vtag_q;

  assign accept        = cmd_v_i & ~busy_i;
  assign lookup_vtag_o = cmd_i.vaddr[`VADDR_WIDTH-1 -: `VTAG_WIDTH];

  always_comb begin
    dec          = '0;
    dec.byte_off = cmd_i.vaddr[1:0];
    case (cmd_i.op)
      e_lw: dec.is_load = 1'b1;
      e_lbu: begin
        dec.is_load = 1'b1;
        dec.is_byte = 1'b1;
      end
      e_sw: dec.is_store = 1'b1;
      e_sb: begin
        dec.is_store = 1'b1;
        dec.is_byte  = 1'b1;
      end
      e_itlb_fill: dec.is_fill = 1'b1;
      default: dec.is_fill = 1'b0;
    endcase
  end

  always_comb begin
    if (translation_en_i) begin
      paddr = {lookup_entry_i.ptag, cmd_i.vaddr[`PAGE_OFFSET_WIDTH-1:0]};
      miss  = ~lookup_hit_i & ~dec.is_fill;
      exc   = lookup_hit_i & ((dec.is_load & ~lookup_entry_i.r)
                            | (dec.is_store & ~lookup_entry_i.w));
    end else begin
      paddr = cmd_i.vaddr[`PADDR_WIDTH-1:0];
      miss  = 1'b0;
      exc   = 1'b0;
    end
  end

  // Only permitted hits reach the memory
  assign dmem_v_o     = accept & (dec.is_load | dec.is_store) & ~miss & ~exc;
  assign dmem_we_o    = dec.is_store;
  assign dmem_addr_o  = paddr[`PADDR_WIDTH-1:2];
  assign dmem_wdata_o = dec.is_byte ? {(`DATA_WIDTH/8){cmd_i.data[7:0]}} : cmd_i.data;
  assign dmem_mask_o  = dec.is_byte ? (`DATA_WIDTH/8)'(1) << dec.byte_off : '1;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      stage_v_q <= 1'b0;
    end else begin
      stage_v_q <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      dec_q  <= dec;
      miss_q <= miss;
      exc_q  <= exc;
      vtag_q <= lookup_vtag_o;
    end
  end

  // Walk request leaves from the registered stage
  assign walk_v_o        = stage_v_q & (miss_q | dec_q.is_fill);
  assign walk_vtag_o     = vtag_q;
  assign walk_is_store_o = dec_q.is_store;
  assign walk_is_fill_o  = dec_q.is_fill;

  assign stage_v_o    = stage_v_q;
  assign stage_dec_o  = dec_q;
  assign stage_miss_o = miss_q;
  assign stage_exc_o  = exc_q;

endmodule

// File: source/dtlb.sv
/* Fully associative data TLB */

`timescale 1ns/1ps
`include "mem_macros.svh"

module dtlb (
  input  logic                     clk_i
  , input  logic                   reset_i
  , input  logic                   flush_i
  , input  logic [`VTAG_WIDTH-1:0] vtag_i
  , output logic                   hit_o
  , output vm_pkg::tlb_entry_s     entry_o
  , tlb_fill_if.tlb                fill
);
  import vm_pkg::*;

  localparam int unsigned idx_width = $clog2(`DTLB_ENTRIES);

  logic [`DTLB_ENTRIES-1:0] valid_q;
  logic [`VTAG_WIDTH-1:0]   vtag_q [`DTLB_ENTRIES];
  tlb_entry_s               entry_q [`DTLB_ENTRIES];
  logic [idx_width-1:0]     rr_ptr_q;
  logic                     write;

  assign write = fill.w_v & ~fill.itlb_not_dtlb;

  always_comb begin
    hit_o   = 1'b0;
    entry_o = '0;
    for (int i = 0; i < `DTLB_ENTRIES; i++) begin
      if (valid_q[i] && (vtag_q[i] == vtag_i)) begin
        hit_o   = 1'b1;
        entry_o = entry_q[i];
      end
    end
  end

  // Flush takes precedence over a fill in the same cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q  <= '0;
      rr_ptr_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (write) begin
      valid_q[rr_ptr_q] <= 1'b1;
      rr_ptr_q          <= rr_ptr_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (write) begin
      vtag_q[rr_ptr_q]  <= fill.vtag;
      entry_q[rr_ptr_q] <= fill.entry;
    end
  end

endmodule

// File: source/page_walker.sv
/* Single-level page walker */

`timescale 1ns/1ps
`include "mem_macros.svh"

module page_walker (
  input  logic                      clk_i
  , input  logic                    reset_i
  , input  logic                    walk_v_i
  , input  logic [`VTAG_WIDTH-1:0]  walk_vtag_i
  , input  logic                    walk_is_store_i
  , input  logic                    walk_is_fill_i
  , input  logic [`PTAG_WIDTH-1:0]  base_ppn_i
  , input  logic [`DATA_WIDTH-1:0]  pte_data_i
  , output logic                    busy_o
  , output logic                    pte_rd_v_o
  , output logic [`PADDR_WIDTH-3:0] pte_addr_o
  , output logic                    itlb_fill_v_o
  , output logic [`VADDR_WIDTH-1:0] itlb_fill_vaddr_o
  , output logic [`PTAG_WIDTH-1:0]  itlb_fill_ppn_o
  , output logic                    page_fault_v_o
  , output logic [`VADDR_WIDTH-1:0] page_fault_vaddr_o
  , tlb_fill_if.walker              fill
);
  import vm_pkg::*;

  typedef enum logic [1:0] {e_idle, e_read, e_check} state_e;
  typedef enum logic [1:0] {e_walk_load, e_walk_store, e_walk_fill} kind_e;

  state_e                  state_q;
  kind_e                   kind_q;
  logic [`VTAG_WIDTH-1:0]  vtag_q;
  logic [`PADDR_WIDTH-1:0] pte_paddr;
  logic [`VADDR_WIDTH-1:0] page_vaddr;
  logic                    check, leaf_v;
  pte_s                    pte;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= e_idle;
    end else begin
      case (state_q)
        e_idle:  state_q <= walk_v_i ? e_read : e_idle;
        e_read:  state_q <= e_check;
        default: state_q <= e_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == e_idle) && walk_v_i) begin
      vtag_q <= walk_vtag_i;
      if (walk_is_fill_i) begin
        kind_q <= e_walk_fill;
      end else begin
        kind_q <= walk_is_store_i ? e_walk_store : e_walk_load;
      end
    end
  end

  // PTE sits at base_ppn * 256 + vtag * 4
  assign pte_paddr  = {base_ppn_i, `PAGE_OFFSET_WIDTH'(0)} + `PADDR_WIDTH'({vtag_q, 2'b00});
  assign pte_addr_o = pte_paddr[`PADDR_WIDTH-1:2];
  assign pte_rd_v_o = (state_q == e_read);
  assign busy_o     = (state_q != e_idle);

  assign pte        = pte_s'(pte_data_i);
  assign check      = (state_q == e_check);
  assign leaf_v     = check & pte.v;
  assign page_vaddr = {vtag_q, `PAGE_OFFSET_WIDTH'(0)};

  assign fill.w_v           = leaf_v;
  assign fill.vtag          = vtag_q;
  assign fill.entry         = '{ptag: pte.ppn, r: pte.r, w: pte.w};
  assign fill.itlb_not_dtlb = (kind_q == e_walk_fill);

  assign itlb_fill_v_o      = leaf_v & (kind_q == e_walk_fill);
  assign itlb_fill_vaddr_o  = page_vaddr;
  assign itlb_fill_ppn_o    = pte.ppn;
  assign page_fault_v_o     = check & ~pte.v;
  assign page_fault_vaddr_o = page_vaddr;

endmodule

// File: source/data_mem.sv
/* Local data memory */

`timescale 1ns/1ps
`include "mem_macros.svh"

module data_mem (
  input  logic                       clk_i
  , input  logic                     v_i
  , input  logic                     we_i
  , input  logic [`PADDR_WIDTH-3:0]  addr_i
  , input  logic [`DATA_WIDTH-1:0]   wdata_i
  , input  logic [`DATA_WIDTH/8-1:0] mask_i
  , input  logic                     pte_rd_v_i
  , input  logic [`PADDR_WIDTH-3:0]  pte_addr_i
  , output logic [`DATA_WIDTH-1:0]   rdata_o
);

  logic [`DATA_WIDTH-1:0] mem_q [`DMEM_WORDS];

  // Byte lane writes
  always_ff @(posedge clk_i) begin
    if (v_i && we_i) begin
      for (int b = 0; b < `DATA_WIDTH/8; b++) begin
        if (mask_i[b]) begin
          mem_q[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // Walker read wins
  always_ff @(posedge clk_i) begin
    if (pte_rd_v_i) begin
      rdata_o <= mem_q[pte_addr_i];
    end else if (v_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

// File: source/mem_resp_gen.sv
/* Load alignment and response */

`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_resp_gen (
  input  logic                     clk_i
  , input  logic                   reset_i
  , input  logic                   stage_v_i
  , input  mmu_pkg::op_dec_s       stage_dec_i
  , input  logic                   stage_miss_i
  , input  logic                   stage_exc_i
  , input  logic [`DATA_WIDTH-1:0] rdata_i
  , output logic                   resp_v_o
  , output mmu_pkg::mem_resp_s     resp_o
);
  import mmu_pkg::*;

  mem_resp_s  resp, align_q;
  logic       resp_v, align_v_q;
  logic [7:0] sel_byte;

  assign sel_byte = rdata_i[{stage_dec_i.byte_off, 3'b000} +: 8];

  always_comb begin
    resp.miss_v = stage_miss_i;
    resp.exc_v  = stage_exc_i;
    if (stage_miss_i || stage_exc_i || !stage_dec_i.is_load) begin
      resp.data = '0;
    end else if (stage_dec_i.is_byte) begin
      resp.data = `DATA_WIDTH'(sel_byte);
    end else begin
      resp.data = rdata_i;
    end
  end

  // Fills never answer
  assign resp_v = stage_v_i & ~stage_dec_i.is_fill;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      align_v_q <= 1'b0;
      resp_v_o  <= 1'b0;
    end else begin
      align_v_q <= resp_v;
      resp_v_o  <= align_v_q;
    end
  end

  always_ff @(posedge clk_i) begin
    align_q <= resp;
    resp_o  <= align_q;
  end

endmodule

// File: source/mem_top.sv
/* Memory unit top level */

`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_top (
  input  logic                      clk_i
  , input  logic                    reset_i
  , input  logic                    cmd_v_i
  , input  mmu_pkg::mem_op_e        cmd_op_i
  , input  logic [`VADDR_WIDTH-1:0] cmd_vaddr_i
  , input  logic [`DATA_WIDTH-1:0]  cmd_data_i
  , input  logic                    translation_en_i
  , input  logic [`PTAG_WIDTH-1:0]  base_ppn_i
  , input  logic                    tlb_fence_i
  , output logic                    cmd_ready_o
  , output logic                    resp_v_o
  , output logic [`DATA_WIDTH-1:0]  resp_data_o
  , output logic                    resp_miss_o
  , output logic                    resp_exc_o
  , output logic                    itlb_fill_v_o
  , output logic [`VADDR_WIDTH-1:0] itlb_fill_vaddr_o
  , output logic [`PTAG_WIDTH-1:0]  itlb_fill_ppn_o
  , output logic                    page_fault_v_o
  , output logic [`VADDR_WIDTH-1:0] page_fault_vaddr_o
);
  import mmu_pkg::*;
  import vm_pkg::*;

  mmu_cmd_s                  cmd;
  op_dec_s                   stage_dec;
  mem_resp_s                 resp;
  tlb_entry_s                lookup_entry;
  logic [`VTAG_WIDTH-1:0]    lookup_vtag, walk_vtag;
  logic                      lookup_hit, busy, pte_rd_v;
  logic                      dmem_v, dmem_we;
  logic                      walk_v, walk_is_store, walk_is_fill;
  logic                      stage_v, stage_miss, stage_exc;
  logic [`PADDR_WIDTH-3:0]   dmem_addr, pte_addr;
  logic [`DATA_WIDTH-1:0]    dmem_wdata, rdata;
  logic [`DATA_WIDTH/8-1:0]  dmem_mask;

  tlb_fill_if fill_if ();

  assign cmd         = '{op: cmd_op_i, vaddr: cmd_vaddr_i, data: cmd_data_i};
  assign cmd_ready_o = ~busy;
  assign resp_data_o = resp.data;
  assign resp_miss_o = resp.miss_v;
  assign resp_exc_o  = resp.exc_v;

  mmu_cmd_decode i_decode (
    .clk_i(clk_i), .reset_i(reset_i), .cmd_v_i(cmd_v_i), .cmd_i(cmd), .busy_i(busy)
    , .translation_en_i(translation_en_i), .lookup_hit_i(lookup_hit)
    , .lookup_entry_i(lookup_entry), .lookup_vtag_o(lookup_vtag)
    , .dmem_v_o(dmem_v), .dmem_we_o(dmem_we), .dmem_addr_o(dmem_addr)
    , .dmem_wdata_o(dmem_wdata), .dmem_mask_o(dmem_mask)
    , .walk_v_o(walk_v), .walk_vtag_o(walk_vtag)
    , .walk_is_store_o(walk_is_store), .walk_is_fill_o(walk_is_fill)
    , .stage_v_o(stage_v), .stage_dec_o(stage_dec)
    , .stage_miss_o(stage_miss), .stage_exc_o(stage_exc)
  );

  dtlb i_dtlb (
    .clk_i(clk_i), .reset_i(reset_i), .flush_i(tlb_fence_i), .vtag_i(lookup_vtag)
    , .hit_o(lookup_hit), .entry_o(lookup_entry), .fill(fill_if.tlb)
  );

  page_walker i_walker (
    .clk_i(clk_i), .reset_i(reset_i), .walk_v_i(walk_v), .walk_vtag_i(walk_vtag)
    , .walk_is_store_i(walk_is_store), .walk_is_fill_i(walk_is_fill)
    , .base_ppn_i(base_ppn_i), .pte_data_i(rdata), .busy_o(busy)
    , .pte_rd_v_o(pte_rd_v), .pte_addr_o(pte_addr)
    , .itlb_fill_v_o(itlb_fill_v_o), .itlb_fill_vaddr_o(itlb_fill_vaddr_o)
    , .itlb_fill_ppn_o(itlb_fill_ppn_o), .page_fault_v_o(page_fault_v_o)
    , .page_fault_vaddr_o(page_fault_vaddr_o), .fill(fill_if.walker)
  );

  data_mem i_dmem (
    .clk_i(clk_i), .v_i(dmem_v), .we_i(dmem_we), .addr_i(dmem_addr)
    , .wdata_i(dmem_wdata), .mask_i(dmem_mask)
    , .pte_rd_v_i(pte_rd_v), .pte_addr_i(pte_addr), .rdata_o(rdata)
  );

  mem_resp_gen i_resp (
    .clk_i(clk_i), .reset_i(reset_i), .stage_v_i(stage_v), .stage_dec_i(stage_dec)
    , .stage_miss_i(stage_miss), .stage_exc_i(stage_exc), .rdata_i(rdata)
    , .resp_v_o(resp_v_o), .resp_o(resp)
  );

endmodule

// File: verif/tb_mem_top.sv
/* Memory unit testbench */

`timescale 1ns/1ps
`include "mem_macros.svh"

module tb_mem_top;
  import mmu_pkg::*;

  // Six tests, each well under 150 cycles
  localparam int max_cycles = 6 * 150;
  localparam logic [`PTAG_WIDTH-1:0] pt_base = 4'h8;

  logic                    clk_i = 1'b0;
  logic                    reset_i, cmd_v_i, translation_en_i, tlb_fence_i;
  mem_op_e                 cmd_op_i;
  logic [`VADDR_WIDTH-1:0] cmd_vaddr_i, itlb_fill_vaddr_o, page_fault_vaddr_o;
  logic [`DATA_WIDTH-1:0]  cmd_data_i, resp_data_o;
  logic [`PTAG_WIDTH-1:0]  base_ppn_i, itlb_fill_ppn_o;
  logic                    cmd_ready_o, resp_v_o, resp_miss_o, resp_exc_o;
  logic                    itlb_fill_v_o, page_fault_v_o;
  logic [`DATA_WIDTH-1:0]  model_mem [`DMEM_WORDS];
  int                      cycle = 0;
  int                      value_errs = 0;
  int                      proto_errs = 0;

  mem_top i_mem_top (.*);

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
    if (cycle >= max_cycles) begin
      $display("Timeout after %0d cycles with tests still running", cycle);
      $display("Done: errors found");
      $finish;
    end
  end

  function automatic mem_resp_s make_resp(input logic [`DATA_WIDTH-1:0] data,
                                          input logic miss, input logic exc);
    mem_resp_s r;
    r.data   = data;
    r.miss_v = miss;
    r.exc_v  = exc;
    return r;
  endfunction

  // Perm bits are {w, r, v}, frame number sits in bits 7 to 4
  function automatic logic [`DATA_WIDTH-1:0] pte_word(input logic [2:0] perm,
                                                      input logic [`PTAG_WIDTH-1:0] ppn);
    return {24'h0, ppn, 1'b0, perm};
  endfunction

  function automatic logic [`DATA_WIDTH-1:0] model_word(input logic [`PADDR_WIDTH-1:0] pa);
    return model_mem[pa[11:2]];
  endfunction

  function automatic logic [`DATA_WIDTH-1:0] model_byte(input logic [`PADDR_WIDTH-1:0] pa);
    return {24'h0, model_mem[pa[11:2]][8*pa[1:0] +: 8]};
  endfunction

  task automatic check_resp(input mem_resp_s exp);
    if (resp_v_o !== 1'b1) begin
      $display("No response in cycle %0d where one was due", cycle);
      proto_errs++;
    end else begin
      if (resp_data_o !== exp.data) begin
        $display("[ERROR] resp_data_o got %h exp %h", resp_data_o, exp.data);
        value_errs++;
      end
      if (resp_miss_o !== exp.miss_v) begin
        $display("[ERROR] resp_miss_o got %h exp %h", resp_miss_o, exp.miss_v);
        value_errs++;
      end
      if (resp_exc_o !== exp.exc_v) begin
        $display("[ERROR] resp_exc_o got %h exp %h", resp_exc_o, exp.exc_v);
        value_errs++;
      end
    end
  endtask

  task automatic check_fill(input logic [`VADDR_WIDTH-1:0] vaddr,
                            input logic [`PTAG_WIDTH-1:0] ppn);
    if (itlb_fill_v_o !== 1'b1) begin
      $display("No instruction TLB fill pulse in cycle %0d", cycle);
      proto_errs++;
    end else begin
      if (itlb_fill_vaddr_o !== vaddr) begin
        $display("[ERROR] itlb_fill_vaddr_o got %h exp %h", itlb_fill_vaddr_o, vaddr);
        value_errs++;
      end
      if (itlb_fill_ppn_o !== ppn) begin
        $display("[ERROR] itlb_fill_ppn_o got %h exp %h", itlb_fill_ppn_o, ppn);
        value_errs++;
      end
    end
  endtask

  task automatic check_fault(input logic [`VADDR_WIDTH-1:0] vaddr);
    if (page_fault_v_o !== 1'b1) begin
      $display("No page fault pulse in cycle %0d", cycle);
      proto_errs++;
    end else if (page_fault_vaddr_o !== vaddr) begin
      $display("[ERROR] page_fault_vaddr_o got %h exp %h", page_fault_vaddr_o, vaddr);
      value_errs++;
    end
  endtask

  task automatic expect_ready(input logic exp);
    if (cmd_ready_o !== exp) begin
      $display("[ERROR] cmd_ready_o got %h exp %h", cmd_ready_o, exp);
      value_errs++;
    end
  endtask

  task automatic wait_cycle(input int target);
    while (cycle < target) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  // Holds the command until the accepting edge, returns that edge's count
  task automatic issue(input mem_op_e op, input logic [`VADDR_WIDTH-1:0] vaddr,
                       input logic [`DATA_WIDTH-1:0] data, output int acc);
    cmd_v_i     = 1'b1;
    cmd_op_i    = op;
    cmd_vaddr_i = vaddr;
    cmd_data_i  = data;
    while (!cmd_ready_o) begin
      @(posedge clk_i);
      #1;
    end
    @(posedge clk_i);
    #1;
    cmd_v_i = 1'b0;
    acc     = cycle;
  endtask

  task automatic do_access(input mem_op_e op, input logic [`VADDR_WIDTH-1:0] vaddr,
                           input logic [`DATA_WIDTH-1:0] data, input mem_resp_s exp);
    int acc;
    issue(op, vaddr, data, acc);
    wait_cycle(acc + 2);
    check_resp(exp);
  endtask

  task automatic store_word(input logic [`VADDR_WIDTH-1:0] vaddr,
                            input logic [`PADDR_WIDTH-1:0] pa,
                            input logic [`DATA_WIDTH-1:0] data);
    do_access(e_sw, vaddr, data, make_resp('0, 1'b0, 1'b0));
    model_mem[pa[11:2]] = data;
  endtask

  // Entry lives at base * 256 + vtag * 4
  task automatic write_pte(input logic [7:0] vtag, input logic [`DATA_WIDTH-1:0] pte);
    logic [`PADDR_WIDTH-1:0] pa;
    pa = {pt_base, 8'h00} + {2'b00, vtag, 2'b00};
    store_word({4'h0, pa}, pa, pte);
  endtask

  // First store misses and walks, the replay writes
  task automatic touch_page(input logic [`VADDR_WIDTH-1:0] vaddr,
                            input logic [`PADDR_WIDTH-1:0] pa);
    logic [`DATA_WIDTH-1:0] d;
    d = $urandom;
    do_access(e_sw, vaddr, d, make_resp('0, 1'b1, 1'b0));
    store_word(vaddr, pa, d);
  endtask

  task automatic untranslated_access();
    logic [`DATA_WIDTH-1:0] d;
    int a0, a1;
    translation_en_i = 1'b0;
    store_word(16'h0040, 12'h040, $urandom);
    store_word(16'h0044, 12'h044, $urandom);
    d = $urandom;
    do_access(e_sb, 16'h0041, d, make_resp('0, 1'b0, 1'b0));
    model_mem[16][15:8] = d[7:0];
    do_access(e_lw, 16'h0040, '0, make_resp(model_mem[16], 1'b0, 1'b0));
    do_access(e_lbu, 16'h0041, '0, make_resp(model_byte(12'h041), 1'b0, 1'b0));
    do_access(e_lbu, 16'h0046, '0, make_resp(model_byte(12'h046), 1'b0, 1'b0));
    issue(e_lw, 16'h0044, '0, a0);
    issue(e_lw, 16'h0040, '0, a1);
    wait_cycle(a0 + 2);
    check_resp(make_resp(model_mem[17], 1'b0, 1'b0));
    wait_cycle(a1 + 2);
    check_resp(make_resp(model_mem[16], 1'b0, 1'b0));
  endtask

  task automatic miss_and_replay();
    int acc;
    translation_en_i = 1'b0;
    base_ppn_i       = pt_base;
    write_pte(8'h10, pte_word(3'b111, 4'h2));
    write_pte(8'h11, pte_word(3'b011, 4'h3));
    write_pte(8'h12, pte_word(3'b101, 4'h4));
    write_pte(8'h13, pte_word(3'b110, 4'h5));
    write_pte(8'h20, pte_word(3'b011, 4'h5));
    write_pte(8'h14, pte_word(3'b111, 4'h6));
    write_pte(8'h15, pte_word(3'b111, 4'h7));
    write_pte(8'h16, pte_word(3'b111, 4'h9));
    write_pte(8'h17, pte_word(3'b111, 4'hA));
    store_word(16'h0210, 12'h210, $urandom);
    store_word(16'h0310, 12'h310, $urandom);
    translation_en_i = 1'b1;
    issue(e_lw, 16'h1010, '0, acc);
    wait_cycle(acc + 1);
    expect_ready(1'b0);
    wait_cycle(acc + 2);
    check_resp(make_resp('0, 1'b1, 1'b0));
    expect_ready(1'b0);
    wait_cycle(acc + 3);
    expect_ready(1'b1);
    do_access(e_lw, 16'h1010, '0, make_resp(model_word(12'h210), 1'b0, 1'b0));
    store_word(16'h1014, 12'h214, $urandom);
    do_access(e_lw, 16'h1014, '0, make_resp(model_word(12'h214), 1'b0, 1'b0));
  endtask

  task automatic permission_faults();
    logic [`DATA_WIDTH-1:0] d;
    d = ~model_word(12'h310);
    do_access(e_sw, 16'h1110, d, make_resp('0, 1'b1, 1'b0));
    do_access(e_sw, 16'h1110, d, make_resp('0, 1'b0, 1'b1));
    do_access(e_lw, 16'h1110, '0, make_resp(model_word(12'h310), 1'b0, 1'b0));
    do_access(e_lw, 16'h1210, '0, make_resp('0, 1'b1, 1'b0));
    do_access(e_lw, 16'h1210, '0, make_resp('0, 1'b0, 1'b1));
  endtask

  task automatic invalid_pte_fault();
    int acc;
    issue(e_lw, 16'h1344, '0, acc);
    wait_cycle(acc + 2);
    check_resp(make_resp('0, 1'b1, 1'b0));
    check_fault(16'h1300);
  endtask

  task automatic itlb_fill_op();
    int acc;
    issue(e_itlb_fill, 16'h2030, '0, acc);
    wait_cycle(acc + 2);
    check_fill(16'h2000, 4'h5);
    if (resp_v_o !== 1'b0) begin
      $display("Response seen for an instruction TLB fill in cycle %0d", cycle);
      proto_errs++;
    end
  endtask

  task automatic fence_and_eviction();
    tlb_fence_i = 1'b1;
    @(posedge clk_i);
    #1;
    tlb_fence_i = 1'b0;
    do_access(e_lw, 16'h1010, '0, make_resp('0, 1'b1, 1'b0));
    do_access(e_lw, 16'h1010, '0, make_resp(model_word(12'h210), 1'b0, 1'b0));
    touch_page(16'h1420, 12'h620);
    touch_page(16'h1520, 12'h720);
    touch_page(16'h1620, 12'h920);
    touch_page(16'h1720, 12'hA20);
    // Second page survives, first one went to the fifth
    do_access(e_lw, 16'h1420, '0, make_resp(model_word(12'h620), 1'b0, 1'b0));
    do_access(e_lw, 16'h1010, '0, make_resp('0, 1'b1, 1'b0));
  endtask

  initial begin
    int seed;
    seed             = $urandom(50);
    reset_i          = 1'b1;
    cmd_v_i          = 1'b0;
    cmd_op_i         = e_lw;
    cmd_vaddr_i      = '0;
    cmd_data_i       = '0;
    translation_en_i = 1'b0;
    base_ppn_i       = '0;
    tlb_fence_i      = 1'b0;
    repeat (2) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    untranslated_access();
    miss_and_replay();
    permission_faults();
    invalid_pte_fault();
    itlb_fill_op();
    fence_and_eviction();
    $display("Errors: %0d value, %0d protocol", value_errs, proto_errs);
    if (value_errs + proto_errs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+source
source/mmu_pkg.sv
source/vm_pkg.sv
source/tlb_fill_if.sv
source/mmu_cmd_decode.sv
source/dtlb.sv
source/page_walker.sv
source/data_mem.sv
source/mem_resp_gen.sv
source/mem_top.sv
verif/tb_mem_top.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps
TOP      = tb_mem_top
FILELIST = verilog.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(wildcard source/*.sv source/*.svh verif/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf $(OBJ_DIR)
